/* design/sigdecode_z_pkg.sv */
// ------------------------------
// Constants and group word type shared by the
// ML-DSA signature z decoder
// ------------------------------

package sigdecode_z_pkg;

    // ------------------------------
    // Field geometry
    // ------------------------------

    // Exponent of gamma1, so gamma1 itself is 2^19
    localparam int GAMMA1_BITS = 19;

    // One packed z field spans gamma1 bits plus one
    localparam int Z_BITS = 20;

    // Four fields fill exactly ten bytes
    localparam int COEFFS_PER_GROUP = 4;
    localparam int BYTES_PER_GROUP = 10;

    // Arithmetic width inside a decode unit, wide enough to hold q
    localparam int REG_SIZE = 23;

    // Coefficient width toward the coefficient memory
    // The top bit is always zero
    localparam int COEFF_W = 24;

    // ------------------------------
    // Default configuration
    // ------------------------------

    // ML-DSA prime modulus
    localparam int DEFAULT_MLDSA_Q = 8380417;

    // Coefficients in one polynomial
    localparam int DEFAULT_N_COEFFS = 256;

    // Width of a group index for a polynomial of n_coeffs coefficients
    // A single-group polynomial still gets a one-bit index
    function automatic int group_idx_bits(int n_coeffs);
        int n_groups;
        n_groups = n_coeffs / COEFFS_PER_GROUP;
        return (n_groups > 1) ? $clog2(n_groups) : 1;
    endfunction

    // One ten-byte group seen two ways
    // Byte 0 and field 0 both sit in the least significant bits
    typedef union packed {
        logic [BYTES_PER_GROUP-1:0][7:0]         bytes;
        logic [COEFFS_PER_GROUP-1:0][Z_BITS-1:0] fields;
    } z_group_u;

endpackage

/* design/z_byte_unpacker.sv */
// ------------------------------
// Byte unpacker that gathers ten strobed bytes
// into one group word and flags each full group
// ------------------------------

`timescale 1ns/1ns

module z_byte_unpacker import sigdecode_z_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       byte_valid_i,
    input  logic [7:0] byte_i,
    output logic       group_valid_o,
    output z_group_u   group_word_o
);

    localparam int CNT_W = $clog2(BYTES_PER_GROUP);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES_PER_GROUP - 1);

    // Lane of the next byte within the current group
    logic [CNT_W-1:0] byte_cnt;

    // Group under construction and its value with the current byte merged in
    z_group_u shadow_q;
    z_group_u shadow_next;

    logic last_byte;

    // The tenth byte of a group is arriving this cycle
    assign last_byte = byte_valid_i && (byte_cnt == LAST_BYTE);

    // Drop the incoming byte into its lane
    always_comb begin
        shadow_next = shadow_q;
        shadow_next.bytes[byte_cnt] = byte_i;
    end

    // ------------------------------
    // Byte counter and strobe
    // ------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt      <= '0;
            group_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            // A partial group is thrown away here
            byte_cnt      <= '0;
            group_valid_o <= 1'b0;
        end else begin
            group_valid_o <= last_byte;
            if (last_byte) begin
                byte_cnt <= '0;
            end else if (byte_valid_i) begin
                byte_cnt <= byte_cnt + CNT_W'(1);
            end
        end
    end

    // Collected lanes, only complete once all ten have been written
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shadow_q <= '0;
        end else if (zeroize_i) begin
            shadow_q <= '0;
        end else if (byte_valid_i) begin
            shadow_q <= shadow_next;
        end
    end

    // ------------------------------
    // Output group word
    // ------------------------------

    // Held stable until the next group completes, so the units see a steady input
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            group_word_o <= '0;
        end else if (zeroize_i) begin
            group_word_o <= '0;
        end else if (last_byte) begin
            group_word_o <= shadow_next;
        end
    end

    // A group needs ten byte strobes, so two strobes can never be adjacent
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (!reset_n)
        group_valid_o |=> !group_valid_o
    ) else $error("group_valid_o high in two consecutive cycles");

endmodule

/* design/sigdecode_z_unit.sv */
// ------------------------------
// Decode unit mapping one z field x to
// gamma1 - x, reduced into 0 to q-1
// ------------------------------

`timescale 1ns/1ns

module sigdecode_z_unit import sigdecode_z_pkg::*; #(
    parameter int MLDSA_Q = DEFAULT_MLDSA_Q
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic [Z_BITS-1:0]  data_i,
    output logic [COEFF_W-1:0] data_o
);

    localparam logic [REG_SIZE-1:0] GAMMA1_W = REG_SIZE'(1) << GAMMA1_BITS;
    localparam logic [REG_SIZE-1:0] Q_W = REG_SIZE'(MLDSA_Q);

    // ------------------------------
    // Stage one
    // ------------------------------

    // Subtraction as gamma1 plus the inverted field plus a carry-in of one
    logic [REG_SIZE-1:0] opb0;
    logic [REG_SIZE:0]   diff_full;

    assign opb0 = ~{{(REG_SIZE - Z_BITS){1'b0}}, data_i};
    assign diff_full = {1'b0, GAMMA1_W} + {1'b0, opb0} + (REG_SIZE + 1)'(1);

    // Carry-out is set exactly when the field does not exceed gamma1,
    // meaning the difference is already non-negative
    logic [REG_SIZE-1:0] diff_q;
    logic                carry_q;

    // A cleared unit holds a non-negative zero difference, so its output reads as zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_q  <= '0;
            carry_q <= 1'b1;
        end else if (zeroize_i) begin
            diff_q  <= '0;
            carry_q <= 1'b1;
        end else begin
            diff_q  <= diff_full[REG_SIZE-1:0];
            carry_q <= diff_full[REG_SIZE];
        end
    end

    // ------------------------------
    // Stage two
    // ------------------------------

    // Adding q to a wrapped negative difference drops the 2^23 wrap and
    // leaves a value between q - gamma1 + 1 and q - 1
    logic [REG_SIZE-1:0] corr_sum;

    assign corr_sum = diff_q + Q_W;

    // Zero in the top bit to match the coefficient memory width
    assign data_o = {{(COEFF_W - REG_SIZE){1'b0}}, carry_q ? diff_q : corr_sum};

    // Both the direct and the corrected path must land inside the field
    a_coeff_below_q: assert property (
        @(posedge clk) disable iff (!reset_n)
        data_o < COEFF_W'(MLDSA_Q)
    ) else $error("decoded coefficient %0d not below q", data_o);

endmodule

/* design/z_coeff_collector.sv */
// ------------------------------
// Coefficient collector that registers each decoded
// group with its index and a polynomial-done pulse
// ------------------------------

`timescale 1ns/1ns

module z_coeff_collector import sigdecode_z_pkg::*; #(
    parameter int N_COEFFS = DEFAULT_N_COEFFS
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize_i,
    input  logic                                  group_valid_i,
    input  logic [COEFFS_PER_GROUP*COEFF_W-1:0]   coeff_i,
    output logic                                  coeff_valid_o,
    output logic [COEFFS_PER_GROUP*COEFF_W-1:0]   coeff_o,
    output logic [group_idx_bits(N_COEFFS)-1:0]   group_idx_o,
    output logic                                  poly_done_o
);

    localparam int N_GROUPS = N_COEFFS / COEFFS_PER_GROUP;
    localparam int IDX_W = group_idx_bits(N_COEFFS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_GROUPS - 1);

    // The units need one cycle after the group strobe, so the strobe is
    // delayed to meet their registered results
    logic group_valid_q;

    // Index that the next captured group will carry
    logic [IDX_W-1:0] idx_cnt;

    logic last_group;

    assign last_group = (idx_cnt == LAST_IDX);

    // ------------------------------
    // Strobe alignment and capture
    // ------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            group_valid_q <= 1'b0;
            coeff_valid_o <= 1'b0;
            poly_done_o   <= 1'b0;
            group_idx_o   <= '0;
            idx_cnt       <= '0;
            coeff_o       <= '0;
        end else if (zeroize_i) begin
            // Any group still in the pipeline is dropped
            group_valid_q <= 1'b0;
            coeff_valid_o <= 1'b0;
            poly_done_o   <= 1'b0;
            group_idx_o   <= '0;
            idx_cnt       <= '0;
            coeff_o       <= '0;
        end else begin
            group_valid_q <= group_valid_i;
            coeff_valid_o <= group_valid_q;
            poly_done_o   <= group_valid_q && last_group;
            if (group_valid_q) begin
                coeff_o     <= coeff_i;
                group_idx_o <= idx_cnt;
                // Wrap after the final group so the next polynomial starts at 0
                if (last_group) begin
                    idx_cnt <= '0;
                end else begin
                    idx_cnt <= idx_cnt + IDX_W'(1);
                end
            end
        end
    end

    // The index never reaches a group number that the polynomial lacks
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        int'(group_idx_o) < N_GROUPS
    ) else $error("group index %0d out of range", group_idx_o);

endmodule

/* design/sigdecode_z_top.sv */
// ------------------------------
// ML-DSA signature z decoder, byte stream in,
// four coefficients per group out
// ------------------------------

`timescale 1ns/1ns

module sigdecode_z_top import sigdecode_z_pkg::*; #(
    parameter int MLDSA_Q  = DEFAULT_MLDSA_Q,
    parameter int N_COEFFS = DEFAULT_N_COEFFS
) (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic                                byte_valid_i,
    input  logic [7:0]                          byte_i,
    output logic                                coeff_valid_o,
    output logic [COEFFS_PER_GROUP*COEFF_W-1:0] coeff_o,
    output logic [group_idx_bits(N_COEFFS)-1:0] group_idx_o,
    output logic                                poly_done_o
);

    // Completed group word and its one-cycle strobe
    z_group_u group_word;
    logic     group_valid;

    // Unit results, field 0 in the low bits
    logic [COEFFS_PER_GROUP*COEFF_W-1:0] unit_coeff;

    // ------------------------------
    // Byte unpacking
    // ------------------------------

    z_byte_unpacker u_unpacker (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .byte_valid_i  (byte_valid_i),
        .byte_i        (byte_i),
        .group_valid_o (group_valid),
        .group_word_o  (group_word)
    );

    // ------------------------------
    // Field decoding
    // ------------------------------

    // One unit per field, all running in lockstep on the held group word
    for (genvar i = 0; i < COEFFS_PER_GROUP; i++) begin : g_unit
        sigdecode_z_unit #(
            .MLDSA_Q (MLDSA_Q)
        ) u_unit (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .data_i    (group_word.fields[i]),
            .data_o    (unit_coeff[i*COEFF_W +: COEFF_W])
        );
    end

    // ------------------------------
    // Output collection
    // ------------------------------

    z_coeff_collector #(
        .N_COEFFS (N_COEFFS)
    ) u_collector (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .group_valid_i (group_valid),
        .coeff_i       (unit_coeff),
        .coeff_valid_o (coeff_valid_o),
        .coeff_o       (coeff_o),
        .group_idx_o   (group_idx_o),
        .poly_done_o   (poly_done_o)
    );

endmodule

/* testbench/tb_sigdecode_z.sv */
// ------------------------------
// Testbench for the ML-DSA signature z decoder
// ------------------------------

`timescale 1ns/1ns

module tb_sigdecode_z import sigdecode_z_pkg::*; ();

    localparam int IDX_W = group_idx_bits(DEFAULT_N_COEFFS);
    localparam int N_GROUPS = DEFAULT_N_COEFFS / COEFFS_PER_GROUP;
    localparam int POLY_BYTES = N_GROUPS * BYTES_PER_GROUP;
    localparam int GROUP_W = COEFFS_PER_GROUP * COEFF_W;
    localparam int WORD_W = BYTES_PER_GROUP * 8;
    localparam int GAMMA1 = 1 << GAMMA1_BITS;

    // Three polynomials' worth of bytes, each byte taking up to three
    // cycles on average with gaps, plus margin for reset and draining
    localparam int TIMEOUT_CYCLES = 3 * POLY_BYTES * 3 + 240;

    localparam logic [15:0] LFSR_SEED = 16'd48223;

    logic               clk;
    logic               reset_n;
    logic               zeroize_i;
    logic               byte_valid_i;
    logic [7:0]         byte_i;
    logic               coeff_valid_o;
    logic [GROUP_W-1:0] coeff_o;
    logic [IDX_W-1:0]   group_idx_o;
    logic               poly_done_o;

    // Expected results, one entry per group sent
    logic [GROUP_W-1:0] exp_coeff_q[$];
    logic [IDX_W-1:0]   exp_idx_q[$];
    logic               exp_done_q[$];

    // Head of the queue, taken off when an output group shows up
    logic [GROUP_W-1:0] exp_coeff;
    logic [IDX_W-1:0]   exp_idx;
    logic               exp_done;
    logic               exp_present;

    logic [15:0] lfsr;
    int          err_count;
    int          err_at_start;
    int          tests_passed;
    int          tests_failed;
    int          test_num;
    int          cycle_count;
    int          model_idx;

    sigdecode_z_top dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .byte_valid_i  (byte_valid_i),
        .byte_i        (byte_i),
        .coeff_valid_o (coeff_valid_o),
        .coeff_o       (coeff_o),
        .group_idx_o   (group_idx_o),
        .poly_done_o   (poly_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Stimulus and reference helpers
    // ------------------------------

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit, new bits enter at the bottom
    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = {val[6:0], lfsr[0]};
        end
    endtask

    // gamma1 - x, lifted by q when it goes negative
    function automatic logic [COEFF_W-1:0] decode_field(input logic [Z_BITS-1:0] x);
        int v;
        v = GAMMA1 - int'(x);
        if (v < 0) begin
            v = v + DEFAULT_MLDSA_Q;
        end
        return COEFF_W'(v);
    endfunction

    // Collects the top bit of each coefficient, which must stay clear
    function automatic logic [COEFFS_PER_GROUP-1:0] top_bits(input logic [GROUP_W-1:0] c);
        logic [COEFFS_PER_GROUP-1:0] t;
        for (int f = 0; f < COEFFS_PER_GROUP; f++) begin
            t[f] = c[f*COEFF_W + COEFF_W - 1];
        end
        return t;
    endfunction

    task automatic expect_group(input logic [WORD_W-1:0] word);
        logic [GROUP_W-1:0] coeffs;
        for (int f = 0; f < COEFFS_PER_GROUP; f++) begin
            coeffs[f*COEFF_W +: COEFF_W] = decode_field(word[f*Z_BITS +: Z_BITS]);
        end
        exp_coeff_q.push_back(coeffs);
        exp_idx_q.push_back(IDX_W'(model_idx));
        exp_done_q.push_back(model_idx == N_GROUPS - 1);
        model_idx = (model_idx + 1) % N_GROUPS;
    endtask

    // Strobe stays high when no gap follows, giving back-to-back bytes
    task automatic send_byte(input logic [7:0] b, input int gap);
        @(negedge clk);
        byte_valid_i = 1'b1;
        byte_i = b;
        repeat (gap) begin
            @(negedge clk);
            byte_valid_i = 1'b0;
        end
    endtask

    task automatic send_group(input logic [WORD_W-1:0] word, input logic gaps);
        logic [7:0] gap_bits;
        int         gap;
        for (int k = 0; k < BYTES_PER_GROUP; k++) begin
            gap = 0;
            if (gaps) begin
                take_bits(1, gap_bits);
                if (gap_bits[0]) begin
                    take_bits(2, gap_bits);
                    gap = int'(gap_bits[1:0]) + 1;
                end
            end
            if (k == BYTES_PER_GROUP - 1) begin
                expect_group(word);
            end
            send_byte(word[k*8 +: 8], gap);
        end
    endtask

    task automatic random_word(output logic [WORD_W-1:0] word);
        logic [7:0] b;
        for (int k = 0; k < BYTES_PER_GROUP; k++) begin
            take_bits(8, b);
            word[k*8 +: 8] = b;
        end
    endtask

    // Clears the DUT and the model together, the index restarts at 0
    task automatic apply_zeroize();
        @(negedge clk);
        byte_valid_i = 1'b0;
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i = 1'b0;
        exp_coeff_q.delete();
        exp_idx_q.delete();
        exp_done_q.delete();
        model_idx = 0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        byte_valid_i = 1'b0;
        while (exp_coeff_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
    endtask

    task automatic start_test();
        err_at_start = err_count;
        test_num = test_num + 1;
    endtask

    task automatic finish_test(input string name);
        if (err_count == err_at_start) begin
            tests_passed = tests_passed + 1;
            $display("Test %0d %s: PASS", test_num, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: FAIL with %0d errors", test_num, name,
                     err_count - err_at_start);
        end
    endtask

    // ------------------------------
    // Checking
    // ------------------------------

    // Outputs change on the rising edge, so the head is taken off half a cycle later
    // and stays put for the assertions at the next rising edge
    always @(negedge clk) begin
        if (reset_n && coeff_valid_o) begin
            if (exp_coeff_q.size() != 0) begin
                exp_coeff = exp_coeff_q.pop_front();
                exp_idx = exp_idx_q.pop_front();
                exp_done = exp_done_q.pop_front();
                exp_present = 1'b1;
            end else begin
                exp_present = 1'b0;
            end
        end
    end

    a_quiet_in_reset: assert property (
        @(posedge clk) !reset_n |-> (!coeff_valid_o && !poly_done_o)
    ) else begin
        err_count = err_count + 1;
        $display("Output strobe seen while reset was asserted at %0t ns", $time);
    end

    a_output_expected: assert property (
        @(posedge clk) disable iff (!reset_n) coeff_valid_o |-> exp_present
    ) else begin
        err_count = err_count + 1;
        $display("Coefficient group appeared at %0t ns with no group pending", $time);
    end

    a_coeff_match: assert property (
        @(posedge clk) disable iff (!reset_n)
        (coeff_valid_o && exp_present) |-> (coeff_o == exp_coeff)
    ) else begin
        err_count = err_count + 1;
        $display("** Error [%0t] coeff_o %h, expected %h", $time, $sampled(coeff_o), exp_coeff);
    end

    a_idx_match: assert property (
        @(posedge clk) disable iff (!reset_n)
        (coeff_valid_o && exp_present) |-> (group_idx_o == exp_idx)
    ) else begin
        err_count = err_count + 1;
        $display("** Error [%0t] group_idx_o %0d, expected %0d", $time,
                 $sampled(group_idx_o), exp_idx);
    end

    a_done_match: assert property (
        @(posedge clk) disable iff (!reset_n)
        (coeff_valid_o && exp_present) |-> (poly_done_o == exp_done)
    ) else begin
        err_count = err_count + 1;
        $display("** Error [%0t] poly_done_o %0b, expected %0b", $time,
                 $sampled(poly_done_o), exp_done);
    end

    a_done_with_valid: assert property (
        @(posedge clk) disable iff (!reset_n) poly_done_o |-> coeff_valid_o
    ) else begin
        err_count = err_count + 1;
        $display("** Error [%0t] poly_done_o high without coeff_valid_o", $time);
    end

    a_top_bits_zero: assert property (
        @(posedge clk) disable iff (!reset_n) coeff_valid_o |-> (top_bits(coeff_o) == '0)
    ) else begin
        err_count = err_count + 1;
        $display("** Error [%0t] coefficient top bits %b, expected all zero", $time,
                 top_bits($sampled(coeff_o)));
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d groups still outstanding",
                     cycle_count, exp_coeff_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic [WORD_W-1:0] word;
        logic [7:0]        b;

        reset_n = 1'b0;
        zeroize_i = 1'b0;
        byte_valid_i = 1'b0;
        byte_i = '0;
        lfsr = LFSR_SEED;
        exp_coeff = '0;
        exp_idx = '0;
        exp_done = 1'b0;
        exp_present = 1'b0;
        err_count = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_num = 0;
        cycle_count = 0;
        model_idx = 0;

        // Nothing may come out during reset or while no bytes arrive
        start_test();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        repeat (20) @(negedge clk);
        finish_test("reset state");

        // Zero, gamma1, gamma1 + 1 and the largest field, in two lane orders
        start_test();
        send_group({20'hFFFFF, 20'h80001, 20'h80000, 20'h00000}, 1'b0);
        send_group({20'h00000, 20'h80000, 20'h80001, 20'hFFFFF}, 1'b0);
        wait_drain();
        finish_test("boundary fields");

        // Start the polynomial at index 0
        start_test();
        apply_zeroize();
        for (int g = 0; g < N_GROUPS; g++) begin
            random_word(word);
            send_group(word, 1'b0);
        end
        wait_drain();
        finish_test("full polynomial back to back");

        // The previous polynomial wrapped the index, so this one starts at 0 again
        start_test();
        for (int g = 0; g < N_GROUPS; g++) begin
            random_word(word);
            send_group(word, 1'b1);
        end
        wait_drain();
        finish_test("full polynomial with idle gaps");

        // Three groups move the index on, then half a group is thrown away
        start_test();
        for (int g = 0; g < 3; g++) begin
            random_word(word);
            send_group(word, 1'b0);
        end
        wait_drain();
        for (int k = 0; k < 5; k++) begin
            take_bits(8, b);
            send_byte(b, 0);
        end
        apply_zeroize();
        random_word(word);
        send_group(word, 1'b0);
        wait_drain();
        finish_test("zeroize mid group");

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/sigdecode_z_pkg.sv
design/z_byte_unpacker.sv
design/sigdecode_z_unit.sv
design/z_coeff_collector.sv
design/sigdecode_z_top.sv
testbench/tb_sigdecode_z.sv

/* Makefile */
# Verilator build and run for the signature z decoder

TOP     := tb_sigdecode_z
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Mdir $(OBJ_DIR) --top-module $(TOP) -f vlog.f

# The log decides the result, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
